// ==== sources.f ====
+incdir+design
design/cache_pkg.sv
design/core_req_bank_sel.sv
design/cache_bank.sv
design/mem_req_arb.sv
design/core_rsp_merge.sv
design/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
LINT_TOP  ?= cache_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/cache_tb.sv ====
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED         = 32'h80351470;
    localparam logic [31:0] FILL_PATTERN = 32'h5a3c_96e1;
    localparam int          TIMEOUT      = 200;

    // Word address is tag, index, bank, wsel
    localparam logic [15:0] ADDR_A = 16'h1234;  // bank 1, index 6
    localparam logic [15:0] ADDR_B = 16'h5678;  // bank 0, index 7
    localparam logic [15:0] ADDR_C = 16'h2a41;  // bank 0, index 0
    localparam logic [15:0] ADDR_D = 16'h3b86;  // bank 1, index 0

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 core_req_valid;
    cache_pkg::core_req_t core_req;
    logic                 core_req_ready;
    logic                 core_rsp_valid;
    cache_pkg::core_rsp_t core_rsp;
    logic                 core_rsp_ready;
    logic                 mem_req_valid;
    cache_pkg::mem_req_t  mem_req;
    logic                 mem_req_ready;
    logic                 mem_rsp_valid;
    cache_pkg::mem_rsp_t  mem_rsp;
    logic                 mem_rsp_ready;

    logic [31:0]          ref_mem [65536];
    logic [31:0]          rand_state;
    cache_pkg::core_rsp_t rsp_q [$];
    cache_pkg::mem_req_t  mem_q [$];

    cache_top dut0 (.*);

    mem_model #(
        .SEED         (SEED),
        .FILL_PATTERN (FILL_PATTERN)
    ) mem0 (.*);

    always #2 clk = ~clk;

    // Handshakes seen here complete on the next rising edge
    always @(negedge clk) begin
        if (!reset && core_rsp_valid && core_rsp_ready) begin
            rsp_q.push_back(core_rsp);
        end
        if (!reset && mem_req_valid && mem_req_ready) begin
            mem_q.push_back(mem_req);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic end_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_equal(input string test, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", test, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic apply_write(input logic [15:0] addr, input logic [3:0] byteen,
                               input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (byteen[b]) begin
                ref_mem[addr][8 * b +: 8] = data[8 * b +: 8];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Channel helpers

    // Starts at a rising edge and returns at the edge that takes the request
    task automatic issue_req(input logic rw, input logic [15:0] addr, input logic [3:0] byteen,
                             input logic [31:0] data, input logic [3:0] tag);
        int cycles;
        cycles = 0;
        core_req_valid <= 1'b1;
        core_req <= '{rw: rw, addr: addr, byteen: byteen, data: data, tag: tag};
        @(negedge clk);
        while (!core_req_ready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: core request to address %h was never accepted", addr);
                end_with_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        core_req_valid <= 1'b0;
        if (rw) begin
            apply_write(addr, byteen, data);
        end
    endtask

    task automatic wait_rsp(output cache_pkg::core_rsp_t rsp);
        int cycles;
        cycles = 0;
        while (rsp_q.size() == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: no core response arrived");
                end_with_failure();
            end
        end
        rsp = rsp_q.pop_front();
    endtask

    task automatic wait_mem_req(output cache_pkg::mem_req_t req);
        int cycles;
        cycles = 0;
        while (mem_q.size() == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: no memory request was issued");
                end_with_failure();
            end
        end
        req = mem_q.pop_front();
    endtask

    task automatic check_line_req(input string test, input cache_pkg::mem_req_t req,
                                  input logic rw, input logic [15:0] addr);
        check_equal({test, " mem rw"}, 128'(rw), 128'(req.rw));
        check_equal({test, " mem addr"}, 128'(addr[15:2]), 128'(req.addr));
        check_equal({test, " mem tag"}, 128'(addr[2]), 128'(req.tag));
    endtask

    task automatic check_write_req(input string test, input logic [15:0] addr,
                                   input logic [3:0] byteen, input logic [31:0] data);
        cache_pkg::mem_req_t req;
        wait_mem_req(req);
        check_line_req(test, req, 1'b1, addr);
        check_equal({test, " mem byteen"}, 128'(16'(byteen) << (4 * addr[1:0])),
                    128'(req.byteen));
        check_equal({test, " mem data"}, 128'(data), 128'(req.data[32 * addr[1:0] +: 32]));
    endtask

    task automatic read_expect(input string test, input logic [15:0] addr,
                               input logic [3:0] tag);
        cache_pkg::core_rsp_t rsp;
        issue_req(1'b0, addr, 4'h0, 32'h0, tag);
        wait_rsp(rsp);
        check_equal({test, " data"}, 128'(ref_mem[addr]), 128'(rsp.data));
        check_equal({test, " tag"}, 128'(tag), 128'(rsp.tag));
    endtask

    // Two responses in either order, matched by tag
    task automatic collect_pair(input string test, input logic [15:0] addr0,
                                input logic [3:0] tag0, input logic [15:0] addr1,
                                input logic [3:0] tag1);
        cache_pkg::core_rsp_t rsp;
        logic [1:0]           seen;
        seen = '0;
        repeat (2) begin
            wait_rsp(rsp);
            if (rsp.tag == tag0) begin
                check_equal({test, " data0"}, 128'(ref_mem[addr0]), 128'(rsp.data));
                seen[0] = 1'b1;
            end else begin
                check_equal({test, " tag1"}, 128'(tag1), 128'(rsp.tag));
                check_equal({test, " data1"}, 128'(ref_mem[addr1]), 128'(rsp.data));
                seen[1] = 1'b1;
            end
        end
        check_equal({test, " both tags"}, 128'(2'b11), 128'(seen));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic reset_outputs();
        @(negedge clk);
        check_equal("reset rsp_valid", '0, 128'(core_rsp_valid));
        check_equal("reset mem_req_valid", '0, 128'(mem_req_valid));
        check_equal("reset req_ready", 128'(1'b1), 128'(core_req_ready));
        @(posedge clk);
    endtask

    task automatic read_miss_then_hit();
        cache_pkg::mem_req_t req;
        read_expect("miss_hit first", ADDR_A, 4'h3);
        check_equal("miss_hit mem count", 128'(1), 128'(mem_q.size()));
        wait_mem_req(req);
        check_line_req("miss_hit", req, 1'b0, ADDR_A);
        read_expect("miss_hit second", ADDR_A, 4'h5);
        check_equal("miss_hit hit mem count", '0, 128'(mem_q.size()));
    endtask

    task automatic write_hit_through();
        logic [31:0] wdata;
        rand_state = xorshift32(rand_state);
        wdata = rand_state;
        // Same line as the earlier miss, next word
        issue_req(1'b1, ADDR_A + 16'd1, 4'b0110, wdata, 4'h4);
        check_write_req("write_hit", ADDR_A + 16'd1, 4'b0110, wdata);
        read_expect("write_hit read", ADDR_A + 16'd1, 4'h6);
        check_equal("write_hit mem count", '0, 128'(mem_q.size()));
    endtask

    task automatic write_miss_no_alloc();
        cache_pkg::mem_req_t req;
        logic [31:0]         wdata;
        rand_state = xorshift32(rand_state);
        wdata = rand_state;
        issue_req(1'b1, ADDR_B, 4'b1001, wdata, 4'h2);
        check_write_req("write_miss", ADDR_B, 4'b1001, wdata);
        read_expect("write_miss read", ADDR_B, 4'h7);
        wait_mem_req(req);
        check_line_req("write_miss read", req, 1'b0, ADDR_B);
    endtask

    task automatic two_bank_reads();
        cache_pkg::mem_req_t req;
        issue_req(1'b0, ADDR_C, 4'h0, 32'h0, 4'h8);
        issue_req(1'b0, ADDR_D, 4'h0, 32'h0, 4'h9);
        collect_pair("two_banks", ADDR_C, 4'h8, ADDR_D, 4'h9);
        check_equal("two_banks mem count", 128'(2), 128'(mem_q.size()));
        // Bank 0 miss reaches memory a cycle before the bank 1 miss
        wait_mem_req(req);
        check_line_req("two_banks first", req, 1'b0, ADDR_C);
        wait_mem_req(req);
        check_line_req("two_banks second", req, 1'b0, ADDR_D);
    endtask

    task automatic rsp_backpressure();
        cache_pkg::core_rsp_t held;
        int                   cycles;
        cycles = 0;
        core_rsp_ready <= 1'b0;
        issue_req(1'b0, ADDR_C, 4'h0, 32'h0, 4'ha);
        issue_req(1'b0, ADDR_D, 4'h0, 32'h0, 4'hb);
        @(negedge clk);
        while (!core_rsp_valid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: core response never became valid under back-pressure");
                end_with_failure();
            end
            @(negedge clk);
        end
        held = core_rsp;
        repeat (6) begin
            @(negedge clk);
            check_equal("backpressure valid", 128'(1'b1), 128'(core_rsp_valid));
            check_equal("backpressure hold", 128'(held), 128'(core_rsp));
        end
        @(posedge clk);
        core_rsp_ready <= 1'b1;
        collect_pair("backpressure", ADDR_C, 4'ha, ADDR_D, 4'hb);
        // Nothing may be delivered twice
        repeat (4) @(posedge clk);
        check_equal("backpressure extra rsp", '0, 128'(rsp_q.size()));
        check_equal("backpressure mem count", '0, 128'(mem_q.size()));
    endtask

    initial begin
        reset          = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        rand_state     = SEED;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = 32'(a) ^ FILL_PATTERN;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        reset_outputs();
        read_miss_then_hit();
        write_hit_through();
        write_miss_no_alloc();
        two_bank_reads();
        rsp_backpressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== verification/mem_model.sv ====
module mem_model #(
    parameter logic [31:0] SEED         = 32'h1,
    parameter logic [31:0] FILL_PATTERN = 32'h0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    output logic                mem_req_ready,
    output logic                mem_rsp_valid,
    output cache_pkg::mem_rsp_t mem_rsp,
    input  logic                mem_rsp_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]         words [65536];
    logic [31:0]         rand_state = SEED;
    logic                busy = 1'b0;
    logic                rsp_valid_q = 1'b0;
    logic [2:0]          delay = '0;
    logic [13:0]         pend_addr = '0;
    cache_pkg::bank_id_t pend_tag = '0;
    cache_pkg::mem_rsp_t rsp_hold = '0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cache_pkg::line_t read_line(input logic [13:0] line_addr);
        cache_pkg::line_t line;
        for (int w = 0; w < 4; w++) begin
            line[32 * w +: 32] = words[{line_addr, 2'(w)}];
        end
        return line;
    endfunction

    assign mem_req_ready = !busy;
    assign mem_rsp_valid = rsp_valid_q;
    assign mem_rsp       = rsp_hold;

    // Writes land when accepted and only one line read is in flight
    always @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < 65536; a++) begin
                words[a] <= 32'(a) ^ FILL_PATTERN;
            end
            rand_state  <= SEED;
            busy        <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else if (rsp_valid_q) begin
            if (mem_rsp_ready) begin
                rsp_valid_q <= 1'b0;
                busy        <= 1'b0;
            end
        end else if (busy) begin
            if (delay == 3'd0) begin
                rsp_valid_q   <= 1'b1;
                rsp_hold.data <= read_line(pend_addr);
                rsp_hold.tag  <= pend_tag;
            end else begin
                delay <= delay - 3'd1;
            end
        end else if (mem_req_valid) begin
            if (mem_req.rw) begin
                for (int b = 0; b < 16; b++) begin
                    if (mem_req.byteen[b]) begin
                        words[{mem_req.addr, 2'(b / 4)}][8 * (b % 4) +: 8] <=
                            mem_req.data[8 * b +: 8];
                    end
                end
            end else begin
                busy       <= 1'b1;
                pend_addr  <= mem_req.addr;
                pend_tag   <= mem_req.tag;
                delay      <= rand_state[2:0];
                rand_state <= xorshift32(rand_state);
            end
        end
    end

endmodule

// ==== design/cache_top.sv ====
module cache_top (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  core_req_valid,
    input  cache_pkg::core_req_t  core_req,
    output logic                  core_req_ready,

    output logic                  core_rsp_valid,
    output cache_pkg::core_rsp_t  core_rsp,
    input  logic                  core_rsp_ready,

    output logic                  mem_req_valid,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_req_ready,

    input  logic                  mem_rsp_valid,
    input  cache_pkg::mem_rsp_t   mem_rsp,
    output logic                  mem_rsp_ready
);

    localparam int NUM_BANKS = $bits(cache_pkg::bank_mask_t);

    cache_pkg::bank_mask_t                  bank_req_valid;
    cache_pkg::bank_req_t                   bank_req;
    cache_pkg::bank_mask_t                  bank_req_ready;
    cache_pkg::bank_mask_t                  bank_rsp_valid;
    cache_pkg::core_rsp_t [NUM_BANKS-1:0]   bank_rsp;
    cache_pkg::bank_mask_t                  bank_rsp_ready;
    cache_pkg::bank_mask_t                  bank_mem_req_valid;
    cache_pkg::mem_req_t [NUM_BANKS-1:0]    bank_mem_req;
    cache_pkg::bank_mask_t                  bank_mem_req_ready;
    cache_pkg::bank_mask_t                  fill_valid;
    cache_pkg::line_t                       fill_data;
    cache_pkg::bank_mask_t                  fill_ready;

    ////////////////////////////////////////////////////////////////////////////

    core_req_bank_sel req_sel (
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        cache_bank #(
            .BANK_ID (i)
        ) bank (
            .clk           (clk),
            .reset         (reset),
            .req_valid     (bank_req_valid[i]),
            .req           (bank_req),
            .req_ready     (bank_req_ready[i]),
            .rsp_valid     (bank_rsp_valid[i]),
            .rsp           (bank_rsp[i]),
            .rsp_ready     (bank_rsp_ready[i]),
            .mem_req_valid (bank_mem_req_valid[i]),
            .mem_req       (bank_mem_req[i]),
            .mem_req_ready (bank_mem_req_ready[i]),
            .fill_valid    (fill_valid[i]),
            .fill_data     (fill_data),
            .fill_ready    (fill_ready[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////

    mem_req_arb mem_arb (
        .clk                (clk),
        .reset              (reset),
        .bank_mem_req_valid (bank_mem_req_valid),
        .bank_mem_req       (bank_mem_req),
        .bank_mem_req_ready (bank_mem_req_ready),
        .mem_req_valid      (mem_req_valid),
        .mem_req            (mem_req),
        .mem_req_ready      (mem_req_ready),
        .mem_rsp_valid      (mem_rsp_valid),
        .mem_rsp            (mem_rsp),
        .mem_rsp_ready      (mem_rsp_ready),
        .fill_valid         (fill_valid),
        .fill_data          (fill_data),
        .fill_ready         (fill_ready)
    );

    core_rsp_merge rsp_merge (
        .clk            (clk),
        .reset          (reset),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

// ==== design/core_rsp_merge.sv ====
module core_rsp_merge (
    input  logic                  clk,
    input  logic                  reset,

    input  cache_pkg::bank_mask_t bank_rsp_valid,
    input  cache_pkg::core_rsp_t [$bits(cache_pkg::bank_mask_t)-1:0] bank_rsp,
    output cache_pkg::bank_mask_t bank_rsp_ready,

    output logic                  core_rsp_valid,
    output cache_pkg::core_rsp_t  core_rsp,
    input  logic                  core_rsp_ready
);

    localparam int NUM_BANKS = $bits(cache_pkg::bank_mask_t);

    cache_pkg::bank_id_t rr_q;
    cache_pkg::bank_id_t sel;

    always_comb begin
        int idx;
        sel = rr_q;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            idx = (int'(rr_q) + i) % NUM_BANKS;
            if (bank_rsp_valid[idx]) begin
                sel = cache_pkg::bank_id_t'(idx);
            end
        end
    end

    assign core_rsp_valid = |bank_rsp_valid;
    assign core_rsp       = bank_rsp[sel];

    always_comb begin
        bank_rsp_ready = '0;
        bank_rsp_ready[sel] = core_rsp_ready;
    end

    // Hold the selected bank while the core stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_q <= '0;
        end else if (core_rsp_valid) begin
            if (!core_rsp_ready) begin
                rr_q <= sel;
            end else if (int'(sel) == NUM_BANKS - 1) begin
                rr_q <= '0;
            end else begin
                rr_q <= sel + 1'b1;
            end
        end
    end

endmodule

// ==== design/mem_req_arb.sv ====
module mem_req_arb (
    input  logic                  clk,
    input  logic                  reset,

    input  cache_pkg::bank_mask_t bank_mem_req_valid,
    input  cache_pkg::mem_req_t [$bits(cache_pkg::bank_mask_t)-1:0] bank_mem_req,
    output cache_pkg::bank_mask_t bank_mem_req_ready,

    output logic                  mem_req_valid,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_req_ready,

    input  logic                  mem_rsp_valid,
    input  cache_pkg::mem_rsp_t   mem_rsp,
    output logic                  mem_rsp_ready,

    output cache_pkg::bank_mask_t fill_valid,
    output cache_pkg::line_t      fill_data,
    input  cache_pkg::bank_mask_t fill_ready
);

    localparam int NUM_BANKS = $bits(cache_pkg::bank_mask_t);

    cache_pkg::bank_id_t rr_q;
    cache_pkg::bank_id_t grant;

    // First requesting bank at or after the pointer
    always_comb begin
        int idx;
        grant = rr_q;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            idx = (int'(rr_q) + i) % NUM_BANKS;
            if (bank_mem_req_valid[idx]) begin
                grant = cache_pkg::bank_id_t'(idx);
            end
        end
    end

    assign mem_req_valid = |bank_mem_req_valid;
    assign mem_req       = bank_mem_req[grant];

    always_comb begin
        bank_mem_req_ready = '0;
        bank_mem_req_ready[grant] = mem_req_ready;
    end

    // Pointer parks on a stalled grant so the output holds steady
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_q <= '0;
        end else if (mem_req_valid) begin
            if (!mem_req_ready) begin
                rr_q <= grant;
            end else if (int'(grant) == NUM_BANKS - 1) begin
                rr_q <= '0;
            end else begin
                rr_q <= grant + 1'b1;
            end
        end
    end

    // Response goes back to the bank named in its tag
    always_comb begin
        fill_valid = '0;
        fill_valid[mem_rsp.tag] = mem_rsp_valid;
    end

    assign fill_data     = mem_rsp.data;
    assign mem_rsp_ready = fill_ready[mem_rsp.tag];

endmodule

// ==== design/cache_bank.sv ====
`include "cache_params.svh"

module cache_bank #(
    parameter int BANK_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      req_valid,
    input  cache_pkg::bank_req_t      req,
    output logic                      req_ready,

    output logic                      rsp_valid,
    output cache_pkg::core_rsp_t      rsp,
    input  logic                      rsp_ready,

    output logic                      mem_req_valid,
    output cache_pkg::mem_req_t       mem_req,
    input  logic                      mem_req_ready,

    input  logic                      fill_valid,
    input  logic [`CACHE_LINE_W-1:0]  fill_data,
    output logic                      fill_ready
);

    typedef enum logic {
        ST_IDLE,
        ST_MISS
    } state_t;

    logic [`CACHE_LINES_PER_BANK-1:0] valid_q;
    logic [`CACHE_TAG_BITS-1:0]       tag_mem [`CACHE_LINES_PER_BANK];
    logic [`CACHE_LINE_W-1:0]         data_mem [`CACHE_LINES_PER_BANK];
    state_t                           state_q;
    cache_pkg::bank_req_t             miss_req_q;

    logic                             hit;
    logic                             req_fire;
    logic                             fill_fire;
    logic [`CACHE_LINE_W-1:0]         hit_line;
    logic [`CACHE_LINE_BYTES-1:0]     wt_byteen;
    logic [`CACHE_LINE_W-1:0]         wt_data;
    logic [`CACHE_LINE_W-1:0]         merged_line;
    logic [`CACHE_MEM_ADDR_W-1:0]     req_line_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup

    assign hit_line = data_mem[req.index];
    assign hit      = valid_q[req.index] && (tag_mem[req.index] == req.line_tag);

    // Both output registers must be free or draining
    assign req_ready = (state_q == ST_IDLE)
                    && (!rsp_valid || rsp_ready)
                    && (!mem_req_valid || mem_req_ready);
    assign req_fire  = req_valid && req_ready;

    assign fill_ready = (state_q == ST_MISS);
    assign fill_fire  = fill_valid && fill_ready;

    assign req_line_addr = {req.line_tag, req.index, cache_pkg::bank_id_t'(BANK_ID)};

    // Write word placed at its slot in the line
    always_comb begin
        wt_byteen = '0;
        wt_data   = '0;
        wt_byteen[req.wsel * `CACHE_WORD_BYTES +: `CACHE_WORD_BYTES] = req.byteen;
        wt_data[req.wsel * `CACHE_WORD_W +: `CACHE_WORD_W]           = req.data;
    end

    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (wt_byteen[b]) begin
                merged_line[b * 8 +: 8] = wt_data[b * 8 +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q       <= ST_IDLE;
            valid_q       <= '0;
            rsp_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            if (req_fire) begin
                if (!req.rw && hit) begin
                    rsp_valid <= 1'b1;
                end else begin
                    mem_req_valid <= 1'b1;
                end
                if (!req.rw && !hit) begin
                    state_q <= ST_MISS;
                end
            end
            if (fill_fire) begin
                valid_q[miss_req_q.index] <= 1'b1;
                rsp_valid                 <= 1'b1;
                state_q                   <= ST_IDLE;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage and output payload

    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (!req.rw && hit) begin
                rsp.data <= hit_line[req.wsel * `CACHE_WORD_W +: `CACHE_WORD_W];
                rsp.tag  <= req.core_tag;
            end
            if (req.rw || !hit) begin
                mem_req.rw     <= req.rw;
                mem_req.addr   <= req_line_addr;
                mem_req.byteen <= req.rw ? wt_byteen : '0;
                mem_req.data   <= wt_data;
                mem_req.tag    <= cache_pkg::bank_id_t'(BANK_ID);
            end
            if (!req.rw && !hit) begin
                miss_req_q <= req;
            end
            // Write hit keeps the line coherent with memory
            if (req.rw && hit) begin
                data_mem[req.index] <= merged_line;
            end
        end
        if (fill_fire) begin
            data_mem[miss_req_q.index] <= fill_data;
            tag_mem[miss_req_q.index]  <= miss_req_q.line_tag;
            rsp.data <= fill_data[miss_req_q.wsel * `CACHE_WORD_W +: `CACHE_WORD_W];
            rsp.tag  <= miss_req_q.core_tag;
        end
    end

endmodule

// ==== design/core_req_bank_sel.sv ====
module core_req_bank_sel (
    input  logic                   core_req_valid,
    input  cache_pkg::core_req_t   core_req,
    output logic                   core_req_ready,

    output cache_pkg::bank_mask_t  bank_req_valid,
    output cache_pkg::bank_req_t   bank_req,
    input  cache_pkg::bank_mask_t  bank_req_ready
);

    cache_pkg::addr_fields_t fields;

    assign fields = core_req.addr;

    // Only the addressed bank sees a valid request
    always_comb begin
        bank_req_valid = '0;
        bank_req_valid[fields.bank] = core_req_valid;
    end

    assign core_req_ready = bank_req_ready[fields.bank];

    // Payload is shared by all banks
    assign bank_req.rw       = core_req.rw;
    assign bank_req.line_tag = fields.tag;
    assign bank_req.index    = fields.index;
    assign bank_req.wsel     = fields.wsel;
    assign bank_req.byteen   = core_req.byteen;
    assign bank_req.data     = core_req.data;
    assign bank_req.core_tag = core_req.tag;

endmodule

// ==== design/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_NUM_BANKS-1:0] bank_mask_t;
    typedef logic [`CACHE_BANK_BITS-1:0] bank_id_t;
    typedef logic [`CACHE_LINE_W-1:0] line_t;

    // Core word address with high bits first
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        bank_id_t                     bank;
        logic [`CACHE_WSEL_BITS-1:0]  wsel;
    } addr_fields_t;

    typedef struct packed {
        logic                          rw;
        logic [`CACHE_ADDR_W-1:0]      addr;
        logic [`CACHE_WORD_BYTES-1:0]  byteen;
        logic [`CACHE_WORD_W-1:0]      data;
        logic [`CACHE_CORE_TAG_W-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [`CACHE_WORD_W-1:0]      data;
        logic [`CACHE_CORE_TAG_W-1:0]  tag;
    } core_rsp_t;

    // Bank bit dropped since the bank number implies it
    typedef struct packed {
        logic                          rw;
        logic [`CACHE_TAG_BITS-1:0]    line_tag;
        logic [`CACHE_INDEX_BITS-1:0]  index;
        logic [`CACHE_WSEL_BITS-1:0]   wsel;
        logic [`CACHE_WORD_BYTES-1:0]  byteen;
        logic [`CACHE_WORD_W-1:0]      data;
        logic [`CACHE_CORE_TAG_W-1:0]  core_tag;
    } bank_req_t;

    typedef struct packed {
        logic                          rw;
        logic [`CACHE_MEM_ADDR_W-1:0]  addr;
        logic [`CACHE_LINE_BYTES-1:0]  byteen;
        line_t                         data;
        bank_id_t                      tag;
    } mem_req_t;

    typedef struct packed {
        line_t                         data;
        bank_id_t                      tag;
    } mem_rsp_t;

endpackage

// ==== design/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Bank split
`define CACHE_NUM_BANKS 2
`define CACHE_BANK_BITS 1

// Word geometry
`define CACHE_WORD_W 32
`define CACHE_WORD_BYTES 4

// Line geometry
`define CACHE_WORDS_PER_LINE 4
`define CACHE_WSEL_BITS 2
`define CACHE_LINE_W 128
`define CACHE_LINE_BYTES 16
`define CACHE_LINES_PER_BANK 8
`define CACHE_INDEX_BITS 3

// Address and tag widths
`define CACHE_ADDR_W 16
`define CACHE_TAG_BITS 10
`define CACHE_MEM_ADDR_W 14
`define CACHE_CORE_TAG_W 4

`endif
